// File: Makefile
SRCS := $(shell cat project.f)

obj_dir/Vadc_display_tb: project.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module adc_display_tb -f project.f -Mdir obj_dir

run: obj_dir/Vadc_display_tb
	@out="$$(./obj_dir/Vadc_display_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: bench/adc_display_sva.sv
//////////////////////////////
// bound checks
// credits, digit selects, idle bus
//////////////////////////////
`timescale 1ns/1ps

module adc_display_sva (
	input logic       sys_clk,
	input logic       sys_rst_n,
	input logic       sample_valid,
	input logic       credit,
	input logic       scl,
	input logic       sda,
	input logic [7:0] seg_choice
);
	logic scl_q;
	logic sda_q;
	logic bus_busy;

	// busy from a start condition until the next stop
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scl_q    <= 1'b1;
			sda_q    <= 1'b1;
			bus_busy <= 1'b0;
		end else begin
			scl_q <= scl;
			sda_q <= sda;
			if (scl && scl_q && sda_q && !sda)
				bus_busy <= 1'b1;
			else if (scl && scl_q && !sda_q && sda)
				bus_busy <= 1'b0;
		end
	end

	a_credit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		sample_valid |-> credit)
		else $error("sample_valid without a credit");

	a_onehot: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$countones(~seg_choice) <= 1)
		else $error("more than one digit selected");

	// between stop and the next start
	a_scl_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!bus_busy |-> scl)
		else $error("scl low while the bus is idle");

endmodule

bind i2c_adc_reader adc_display_sva u_sva (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.sample_valid (sample_valid),
	.credit       (credit),
	.scl          (scl),
	.sda          (sda_in),
	.seg_choice   (8'hFF)
);

bind seg_scan_mux adc_display_sva u_sva (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.sample_valid (1'b0),
	.credit       (1'b1),
	.scl          (1'b1),
	.sda          (1'b1),
	.seg_choice   (seg_choice)
);

// File: bench/adc_display_tb.sv
//////////////////////////////
// adc display testbench
// directed tests through the i2c model and the display
//////////////////////////////
`timescale 1ns/1ps

module adc_display_tb
	import adc_disp_pkg::*;
;
	localparam int SCL_DIV    = 4;
	localparam int SCAN_DIV   = 8;
	localparam int NUM_DIGITS = 3;
	localparam int TX_CYCLES  = 20 * 4 * SCL_DIV + 24;
	localparam int WAIT_LIMIT = 4 * TX_CYCLES;
	// reset test, four fixed bytes, nack pair and twenty random bytes
	localparam int NUM_TX     = 40;
	localparam longint TIMEOUT_NS =
		longint'(NUM_TX) * 3 * (TX_CYCLES + SCAN_DIV * NUM_DIGITS) * 20;

	logic       sys_clk;
	logic       sys_rst_n;
	logic       scl;
	logic       dut_sda_low;
	logic       model_sda_low;
	logic       sda_bus;
	logic [7:0] seg_number;
	logic [7:0] seg_choice;
	int         errors;
	logic [31:0] lcg_state;
	seg_code_e  shown [0:NUM_DIGITS-1];

	// open drain bus with pull-up
	assign sda_bus = !(dut_sda_low || model_sda_low);

	adc_display_top #(
		.DEVICE_ADDR (7'h48),
		.SCL_DIV     (SCL_DIV),
		.NUM_DIGITS  (NUM_DIGITS),
		.SCAN_DIV    (SCAN_DIV)
	) dut (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.sda_in        (sda_bus),
		.scl           (scl),
		.sda_drive_low (dut_sda_low),
		.seg_number    (seg_number),
		.seg_choice    (seg_choice)
	);

	i2c_adc_model #(
		.DEVICE_ADDR (7'h48)
	) model (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.scl       (scl),
		.sda       (sda_bus),
		.drive_low (model_sda_low)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before the tests finished, %0d errors so far", errors);
		$display("Result: FAILED");
		$finish;
	end

	function automatic logic [7:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	function automatic seg_code_e code_of(input logic [7:0] pat);
		for (int i = 0; i < 12; i++) begin
			if (SEG_PATTERNS[i] == pat)
				return seg_code_e'(i);
		end
		return seg_code_e'(4'hF);
	endfunction

	// decimal digit of the byte, leading zeros blank, units always shown
	function automatic seg_code_e expected_code(input int value, input int pos, input bit nack);
		int scale;
		scale = (pos == 0) ? 1 : (pos == 1) ? 10 : 100;
		if (nack)
			return SEG_DASH;
		if (pos > 0 && value < scale)
			return SEG_BLANK;
		return seg_code_e'((value / scale) % 10);
	endfunction

	task automatic wait_reads(input int target);
		int n;
		n = 0;
		while (model.reads < target && n < WAIT_LIMIT) begin
			@(negedge sys_clk);
			n++;
		end
		if (model.reads < target) begin
			errors++;
			$display("timed out waiting for read %0d to complete", target);
		end
	endtask

	task automatic wait_pops(input int target);
		int n;
		n = 0;
		while (model.pops < target && n < WAIT_LIMIT) begin
			@(negedge sys_clk);
			n++;
		end
		if (model.pops < target) begin
			errors++;
			$display("timed out waiting for the model to serve byte %0d", target);
		end
	endtask

	// the reader only starts again once the converter gave its credit back
	task automatic wait_next_start();
		int n;
		n = 0;
		while (!model.active && n < WAIT_LIMIT) begin
			@(negedge sys_clk);
			n++;
		end
		if (!model.active) begin
			errors++;
			$display("timed out waiting for the next transaction to start");
		end
	endtask

	// one full scan, each position caught while its select is low
	task automatic read_display();
		int n;
		for (int sel = 0; sel < NUM_DIGITS; sel++) begin
			n = 0;
			while (seg_choice != ~(8'h01 << sel) && n < 4 * SCAN_DIV * NUM_DIGITS) begin
				@(negedge sys_clk);
				n++;
			end
			if (seg_choice != ~(8'h01 << sel)) begin
				errors++;
				$display("select for digit %0d never went low", sel);
			end
			shown[sel] = code_of(seg_number);
		end
	endtask

	task automatic check_display(input int value, input bit nack);
		seg_code_e exp;
		read_display();
		for (int pos = 0; pos < NUM_DIGITS; pos++) begin
			exp = expected_code(value, pos, nack);
			assert (shown[pos] == exp)
			else begin
				errors++;
				$display("** Error [%0t] value %0d pos %0d shows %0d, expected %0d",
					$time, value, pos, shown[pos], exp);
			end
		end
	endtask

	// load one byte, wait for its transaction, then for the next start
	task automatic show_byte(input logic [7:0] value);
		int p;
		int r;
		p = model.pops;
		model.load_byte(value);
		wait_pops(p + 1);
		r = model.reads;
		wait_reads(r + 1);
		wait_next_start();
		check_display(int'(value), 1'b0);
	endtask

	task automatic reset_and_first_read();
		assert (seg_choice == 8'hFF && scl && sda_bus)
		else begin
			errors++;
			$display("** Error [%0t] outputs not idle in reset", $time);
		end
		sys_rst_n = 1'b1;
		wait_reads(1);
		assert (model.first_addr == {7'h48, 1'b1})
		else begin
			errors++;
			$display("** Error [%0t] first address byte %h", $time, model.first_addr);
		end
	endtask

	task automatic fixed_bytes();
		show_byte(8'd7);
		show_byte(8'd42);
		show_byte(8'd200);
		show_byte(8'd0);
	endtask

	task automatic nack_and_recover();
		int r;
		model.ack_en = 1'b0;
		r = model.reads;
		wait_reads(r + 2);
		wait_next_start();
		check_display(0, 1'b1);
		model.ack_en = 1'b1;
		show_byte(8'd123);
	endtask

	task automatic random_bytes();
		for (int i = 0; i < 20; i++)
			show_byte(lcg_next());
	endtask

	initial begin
		errors    = 0;
		lcg_state = 32'd44011;
		sys_rst_n = 1'b0;
		repeat (3) @(negedge sys_clk);
		reset_and_first_read();
		fixed_bytes();
		nack_and_recover();
		random_bytes();
		$display("tests done, %0d errors", errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: bench/i2c_adc_model.sv
//////////////////////////////
// converter slave model
// serves queued bytes, address ack can be withheld
//////////////////////////////
`timescale 1ns/1ps

module i2c_adc_model #(
	parameter logic [6:0] DEVICE_ADDR = 7'h48
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic scl,
	input  logic sda,
	output logic drive_low
);
	logic [7:0] byte_q [$];
	logic       ack_en;
	int         reads;
	int         pops;
	logic [7:0] first_addr;
	logic       addr_seen;

	logic       scl_q;
	logic       sda_q;
	logic       active;
	int         edge_cnt;
	logic [7:0] shift;
	logic [7:0] cur_byte;
	logic       acked;
	logic       addr_hit;

	assign addr_hit = (shift == {DEVICE_ADDR, 1'b1}) && ack_en;

	initial ack_en = 1'b1;

	task automatic load_byte(input logic [7:0] value);
		byte_q.push_back(value);
	endtask

	// bus watched and driven on the falling sys_clk edge
	always @(negedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scl_q     <= 1'b1;
			sda_q     <= 1'b1;
			active    <= 1'b0;
			edge_cnt  <= 0;
			shift     <= '0;
			cur_byte  <= '0;
			acked     <= 1'b0;
			drive_low <= 1'b0;
			reads     <= 0;
			pops      <= 0;
			addr_seen <= 1'b0;
			first_addr <= '0;
		end else begin
			scl_q <= scl;
			sda_q <= sda;
			if (scl && scl_q && sda_q && !sda) begin
				// start condition
				active    <= 1'b1;
				edge_cnt  <= 0;
				drive_low <= 1'b0;
			end else if (scl && scl_q && !sda_q && sda) begin
				// stop condition
				if (active)
					reads <= reads + 1;
				active    <= 1'b0;
				drive_low <= 1'b0;
			end else if (active && scl && !scl_q) begin
				edge_cnt <= edge_cnt + 1;
				if (edge_cnt < 8)
					shift <= {shift[6:0], sda};
			end else if (active && !scl && scl_q) begin
				if (edge_cnt == 8) begin
					if (!addr_seen) begin
						first_addr <= shift;
						addr_seen  <= 1'b1;
					end
					acked     <= addr_hit;
					drive_low <= addr_hit;
					if (addr_hit && byte_q.size() > 0) begin
						cur_byte <= byte_q.pop_front();
						pops     <= pops + 1;
					end
				end else if (edge_cnt >= 9 && edge_cnt <= 16 && acked) begin
					// data msb first
					drive_low <= !cur_byte[16 - edge_cnt];
				end else begin
					drive_low <= 1'b0;
				end
			end
		end
	end

endmodule

// File: hw/adc_disp_pkg.sv
//////////////////////////////
// adc display shared types
// display codes, sample struct and the segment table
//////////////////////////////
package adc_disp_pkg;

	// sample width of the converter
	localparam int ADC_DATA_W = 8;

	// display code per digit position
	typedef enum logic [3:0] {
		SEG_0     = 4'd0,
		SEG_1     = 4'd1,
		SEG_2     = 4'd2,
		SEG_3     = 4'd3,
		SEG_4     = 4'd4,
		SEG_5     = 4'd5,
		SEG_6     = 4'd6,
		SEG_7     = 4'd7,
		SEG_8     = 4'd8,
		SEG_9     = 4'd9,
		SEG_BLANK = 4'd10,
		SEG_DASH  = 4'd11
	} seg_code_e;

	// one read result from the converter
	typedef struct packed {
		logic                  ack_ok;
		logic [ADC_DATA_W-1:0] data;
	} adc_sample_t;

	// active low, bit order {dp, g, f, e, d, c, b, a}
	// unused codes above dash show nothing
	localparam logic [7:0] SEG_PATTERNS [0:15] = '{
		8'hC0, 8'hF9, 8'hA4, 8'hB0,
		8'h99, 8'h92, 8'h82, 8'hF8,
		8'h80, 8'h90,
		// blank
		8'hFF,
		// dash, segment g only
		8'hBF,
		8'hFF, 8'hFF, 8'hFF, 8'hFF
	};

endpackage

// File: hw/adc_display_top.sv
//////////////////////////////
// adc display top
// i2c reader to bcd to seven segment scan
//////////////////////////////
`timescale 1ns/1ps

module adc_display_top
	import adc_disp_pkg::*;
#(
	parameter logic [6:0] DEVICE_ADDR = 7'h48,
	parameter int         SCL_DIV     = 4,
	parameter int         NUM_DIGITS  = 3,
	parameter int         SCAN_DIV    = 8
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       sda_in,
	output logic       scl,
	output logic       sda_drive_low,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice
);
	adc_sample_t                sample;
	logic                       sample_valid;
	logic                       credit_return;
	seg_code_e [NUM_DIGITS-1:0] digits;
	logic [NUM_DIGITS:0]        blank_chain;
	logic [NUM_DIGITS-1:0][7:0] patterns;

	i2c_adc_reader #(
		.DEVICE_ADDR (DEVICE_ADDR),
		.SCL_DIV     (SCL_DIV)
	) u_reader (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.sda_in        (sda_in),
		.credit_return (credit_return),
		.scl           (scl),
		.sda_drive_low (sda_drive_low),
		.sample        (sample),
		.sample_valid  (sample_valid)
	);

	bin_to_bcd #(
		.NUM_DIGITS (NUM_DIGITS)
	) u_bcd (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.sample        (sample),
		.sample_valid  (sample_valid),
		.digits        (digits),
		.credit_return (credit_return)
	);

	// blanking starts at the top position
	assign blank_chain[NUM_DIGITS] = 1'b1;

	for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit
		seg_digit_encoder #(
			.POS (i)
		) u_enc (
			.sys_clk   (sys_clk),
			.sys_rst_n (sys_rst_n),
			.digit     (digits[i]),
			.blank_in  (blank_chain[i+1]),
			.blank_out (blank_chain[i]),
			.pattern   (patterns[i])
		);
	end

	seg_scan_mux #(
		.NUM_DIGITS (NUM_DIGITS),
		.SCAN_DIV   (SCAN_DIV)
	) u_scan (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.patterns   (patterns),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

// File: hw/bin_to_bcd.sv
//////////////////////////////
// binary to bcd converter
// double dabble, one step per clock
//////////////////////////////
`timescale 1ns/1ps

module bin_to_bcd
	import adc_disp_pkg::*;
#(
	parameter int NUM_DIGITS = 3
) (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  adc_sample_t                sample,
	input  logic                       sample_valid,
	output seg_code_e [NUM_DIGITS-1:0] digits,
	output logic                       credit_return
);
	localparam int BCD_W = 4 * NUM_DIGITS;
	localparam int CNT_W = $clog2(ADC_DATA_W + 1);

	logic [CNT_W-1:0]      step_cnt;
	logic [ADC_DATA_W-1:0] bin_r;
	logic [BCD_W-1:0]      bcd_r;
	logic [BCD_W-1:0]      bcd_adj;
	logic [BCD_W-1:0]      bcd_next;
	logic                  ack_r;

	// add 3 to any nibble of 5 or more, then shift in the next bit
	always_comb begin
		bcd_adj = bcd_r;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			if (bcd_r[4*i +: 4] >= 4'd5)
				bcd_adj[4*i +: 4] = bcd_r[4*i +: 4] + 4'd3;
		end
		bcd_next = {bcd_adj[BCD_W-2:0], bin_r[ADC_DATA_W-1]};
	end

	// capture, then ADC_DATA_W steps; the last step publishes
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			step_cnt      <= '0;
			credit_return <= 1'b0;
			for (int i = 0; i < NUM_DIGITS; i++)
				digits[i] <= SEG_0;
		end else begin
			credit_return <= 1'b0;
			if (sample_valid) begin
				step_cnt <= CNT_W'(ADC_DATA_W);
			end else if (step_cnt != '0) begin
				step_cnt <= step_cnt - 1'b1;
				if (step_cnt == CNT_W'(1)) begin
					credit_return <= 1'b1;
					for (int i = 0; i < NUM_DIGITS; i++)
						digits[i] <= ack_r ? seg_code_e'(bcd_next[4*i +: 4]) : SEG_DASH;
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sample_valid) begin
			bin_r <= sample.data;
			bcd_r <= '0;
			ack_r <= sample.ack_ok;
		end else if (step_cnt != '0) begin
			bin_r <= bin_r << 1;
			bcd_r <= bcd_next;
		end
	end

endmodule

// File: hw/i2c_adc_reader.sv
//////////////////////////////
// i2c adc reader
// reads one byte per transaction from the converter
// and hands it on under a single credit
//////////////////////////////
`timescale 1ns/1ps

module i2c_adc_reader
	import adc_disp_pkg::*;
#(
	parameter logic [6:0] DEVICE_ADDR = 7'h48,
	parameter int         SCL_DIV     = 4
) (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic        sda_in,
	input  logic        credit_return,
	output logic        scl,
	output logic        sda_drive_low,
	output adc_sample_t sample,
	output logic        sample_valid
);
	localparam int         DIV_W     = (SCL_DIV > 1) ? $clog2(SCL_DIV) : 1;
	localparam int         BIT_W     = $clog2(ADC_DATA_W);
	localparam logic [7:0] ADDR_BYTE = {DEVICE_ADDR, 1'b1};

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_ADDR,
		ST_ACK,
		ST_READ,
		ST_NACK,
		ST_STOP
	} i2c_state_e;

	i2c_state_e            state;
	logic [DIV_W-1:0]      div_cnt;
	logic [1:0]            phase;
	logic [BIT_W-1:0]      bit_cnt;
	logic                  qtick;
	logic                  slot_end;
	logic                  sample_point;
	logic                  credit;
	logic                  ack_ok;
	logic [ADC_DATA_W-1:0] rx_shift;

	// four quarters per bit slot, scl high in quarters 1 and 2
	assign qtick        = (div_cnt == DIV_W'(SCL_DIV - 1));
	assign slot_end     = qtick && (phase == 2'd3);
	assign sample_point = qtick && (phase == 2'd1);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			div_cnt <= '0;
			phase   <= '0;
		end else if (state == ST_IDLE) begin
			div_cnt <= '0;
			phase   <= '0;
		end else if (qtick) begin
			div_cnt <= '0;
			phase   <= phase + 2'd1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// single credit, spent by sample_valid
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			credit <= 1'b1;
		else
			credit <= (credit && !sample_valid) || credit_return;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state        <= ST_IDLE;
			bit_cnt      <= '0;
			ack_ok       <= 1'b0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					// no credit means stay parked with the bus released
					if (credit && !sample_valid)
						state <= ST_START;
				end
				ST_START: begin
					if (slot_end) begin
						state   <= ST_ADDR;
						bit_cnt <= BIT_W'(7);
					end
				end
				ST_ADDR: begin
					if (slot_end) begin
						if (bit_cnt == '0)
							state <= ST_ACK;
						else
							bit_cnt <= bit_cnt - 1'b1;
					end
				end
				ST_ACK: begin
					if (sample_point)
						ack_ok <= !sda_in;
					if (slot_end) begin
						// no ack, go straight to stop and report it
						state   <= ack_ok ? ST_READ : ST_STOP;
						bit_cnt <= BIT_W'(ADC_DATA_W - 1);
					end
				end
				ST_READ: begin
					if (slot_end) begin
						if (bit_cnt == '0)
							state <= ST_NACK;
						else
							bit_cnt <= bit_cnt - 1'b1;
					end
				end
				ST_NACK: begin
					if (slot_end)
						state <= ST_STOP;
				end
				ST_STOP: begin
					if (slot_end) begin
						state        <= ST_IDLE;
						sample_valid <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// data bits, msb first
	always_ff @(posedge sys_clk) begin
		if (state == ST_READ && sample_point)
			rx_shift <= {rx_shift[ADC_DATA_W-2:0], sda_in};
	end

	assign sample.ack_ok = ack_ok;
	assign sample.data   = rx_shift;

	// bus drive per state and quarter
	always_comb begin
		scl           = 1'b1;
		sda_drive_low = 1'b0;
		case (state)
			ST_START: begin
				// sda falls while scl high, then scl drops
				scl           = (phase < 2'd2);
				sda_drive_low = 1'b1;
			end
			ST_ADDR: begin
				scl           = (phase == 2'd1) || (phase == 2'd2);
				sda_drive_low = !ADDR_BYTE[bit_cnt];
			end
			ST_ACK, ST_READ, ST_NACK: begin
				scl = (phase == 2'd1) || (phase == 2'd2);
			end
			ST_STOP: begin
				// scl rises first, sda released with scl high
				scl           = (phase != 2'd0);
				sda_drive_low = (phase < 2'd2);
			end
			default: begin
				scl           = 1'b1;
				sda_drive_low = 1'b0;
			end
		endcase
	end

endmodule

// File: hw/seg_digit_encoder.sv
//////////////////////////////
// digit encoder
// segment lookup with leading zero blanking
//////////////////////////////
`timescale 1ns/1ps

module seg_digit_encoder
	import adc_disp_pkg::*;
#(
	parameter int POS = 0
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  seg_code_e  digit,
	input  logic       blank_in,
	output logic       blank_out,
	output logic [7:0] pattern
);
	logic      blank_here;
	seg_code_e shown;

	generate
		if (POS == 0) begin : g_units
			// units position shows its zero
			assign blank_here = 1'b0;
		end else begin : g_upper
			assign blank_here = blank_in && (digit == SEG_0);
		end
	endgenerate

	assign blank_out = blank_here;
	assign shown     = blank_here ? SEG_BLANK : digit;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			pattern <= SEG_PATTERNS[SEG_BLANK];
		else
			pattern <= SEG_PATTERNS[shown];
	end

endmodule

// File: hw/seg_scan_mux.sv
//////////////////////////////
// display scanner
// one digit at a time, active low selects
//////////////////////////////
`timescale 1ns/1ps

module seg_scan_mux #(
	parameter int NUM_DIGITS = 3,
	parameter int SCAN_DIV   = 8
) (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic [NUM_DIGITS-1:0][7:0] patterns,
	output logic [7:0]                 seg_number,
	output logic [7:0]                 seg_choice
);
	localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
	localparam int IDX_W = (NUM_DIGITS > 1) ? $clog2(NUM_DIGITS) : 1;

	logic [DIV_W-1:0] refresh_cnt;
	logic [IDX_W-1:0] scan_idx;
	logic             refresh_wrap;

	assign refresh_wrap = (refresh_cnt == DIV_W'(SCAN_DIV - 1));

	// refresh counter and digit index
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			refresh_cnt <= '0;
			scan_idx    <= '0;
		end else if (refresh_wrap) begin
			refresh_cnt <= '0;
			if (scan_idx == IDX_W'(NUM_DIGITS - 1))
				scan_idx <= '0;
			else
				scan_idx <= scan_idx + 1'b1;
		end else begin
			refresh_cnt <= refresh_cnt + 1'b1;
		end
	end

	// select and pattern change on the same edge
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			seg_choice <= 8'hFF;
			seg_number <= 8'hFF;
		end else begin
			seg_choice <= ~(8'h01 << scan_idx);
			seg_number <= patterns[scan_idx];
		end
	end

endmodule

// File: project.f
hw/adc_disp_pkg.sv
hw/i2c_adc_reader.sv
hw/bin_to_bcd.sv
hw/seg_digit_encoder.sv
hw/seg_scan_mux.sv
hw/adc_display_top.sv
bench/i2c_adc_model.sv
bench/adc_display_sva.sv
bench/adc_display_tb.sv
